/* dv/hci_patterns.txt */
# op W addr wdata err | R addr rdata err | P word wready | C word | A addr valid (hex)
# op E set_dasa dasa rstdaa set_newda newda set_aasa | T cmd_trig resp_trig
R 0D0 00000101 0
R 0D4 00000000 0
R 1A0 00000000 0
R 004 00000000 1
T 1 0
W 0C0 A0000001 0
W 0C0 A0000002 0
W 0C0 A0000003 0
W 0C0 A0000004 0
W 0C0 A0000005 0
W 0C0 A0000006 0
W 0C0 A0000007 0
W 0C0 A0000008 0
R 0D4 00000008 0
T 0 0
W 0C0 DEADBEEF 1
W 0D0 00001414 0
R 0D0 00000808 0
C A0000001
C A0000002
C A0000003
C A0000004
C A0000005
C A0000006
C A0000007
C A0000008
R 0D4 00000000 0
T 1 0
W 0D0 00000304 0
P B0000001 1
P B0000002 1
T 1 0
P B0000003 1
T 1 1
P B0000004 1
P B0000005 1
P B0000006 1
P B0000007 1
P B0000008 1
P BADBAD00 0
R 0C4 B0000001 0
R 0C4 B0000002 0
R 0C4 B0000003 0
R 0C4 B0000004 0
R 0C4 B0000005 0
R 0C4 B0000006 0
R 0C4 B0000007 0
R 0C4 B0000008 0
R 0C4 00000000 1
W 0C0 C0000001 0
P D0000001 1
R 0D4 00000101 0
W 010 00000006 0
R 010 00000000 0
R 0D4 00000000 0
W 1A0 00008055 0
E 0 00 0 0 00 1
A 55 1
E 1 12 0 0 00 0
A 12 1
R 1A0 80128055 0
E 1 21 0 1 43 1
A 21 1
E 0 00 0 1 43 1
A 43 1
E 1 21 1 1 43 1
A 00 0

/* dv/tb_i3c_hci.sv */
// Reads dv/hci_patterns.txt, so it must run from the project root
// Stops at the first mismatch
`timescale 1ns/1ps
`include "i3c_hci_params.svh"

module tb_i3c_hci;
  import i3c_hci_pkg::*;

  logic clk;
  logic rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic cmd_rvalid;
  logic cmd_rready;
  logic [`HCI_DATA_W-1:0] cmd_rdata;
  logic resp_wvalid;
  logic resp_wready;
  logic [`HCI_DATA_W-1:0] resp_wdata;
  daa_event_t daa_event;
  dyn_addr_t dyn_addr;
  logic cmd_thld_trig;
  logic resp_thld_trig;
  int cycles = 0;
  int cycle_limit = 0;  // Set once the pattern file is counted

  i3c_hci dut_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .apb_req_i        (apb_req),
    .apb_rsp_o        (apb_rsp),
    .cmd_rvalid_o     (cmd_rvalid),
    .cmd_rready_i     (cmd_rready),
    .cmd_rdata_o      (cmd_rdata),
    .resp_wvalid_i    (resp_wvalid),
    .resp_wready_o    (resp_wready),
    .resp_wdata_i     (resp_wdata),
    .daa_event_i      (daa_event),
    .dyn_addr_o       (dyn_addr),
    .cmd_thld_trig_o  (cmd_thld_trig),
    .resp_thld_trig_o (resp_thld_trig)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Testbench failed");
      $fatal(1, "Timeout: no progress after %0d cycles", cycles);
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Setup cycle, then access cycle; response sampled inside the access cycle
  task automatic apb_access(input logic write, input logic [`HCI_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  initial begin
    int fd;
    int lines;
    int opno;
    string op;
    string name;
    string rest;
    logic [31:0] a, b, c, d, e, f;
    logic [31:0] rdata;
    logic err;
    void'($urandom(32'he0d9));
    rst_n       = 1'b0;
    apb_req     = '0;
    cmd_rready  = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata  = '0;
    daa_event   = '0;
    lines       = 0;
    opno        = 0;
    fd = $fopen("dv/hci_patterns.txt", "r");
    if (fd == 0) begin
      $display("Testbench failed");
      $fatal(1, "Could not open the pattern file dv/hci_patterns.txt");
    end
    while ($fgets(rest, fd) != 0) begin
      lines++;
    end
    $fclose(fd);
    cycle_limit = 16 * lines + 200;
    fd = $fopen("dv/hci_patterns.txt", "r");
    repeat (5) @(negedge clk);
    check_value("reset cmd_rvalid", 32'h0, {31'b0, cmd_rvalid});  // Command queue empty
    rst_n = 1'b1;

    while ($fscanf(fd, "%s", op) == 1) begin
      if (op.substr(0, 0) == "#") begin
        void'($fgets(rest, fd));  // Skip comment line
      end else begin
        opno++;
        name = $sformatf("op %0d (%s)", opno, op);
        repeat ($urandom_range(3, 0)) @(negedge clk);
        case (op)
          "W": begin
            void'($fscanf(fd, "%h %h %h", a, b, c));
            apb_access(1'b1, a[`HCI_ADDR_W-1:0], b, rdata, err);
            check_value({name, " pslverr"}, c, {31'b0, err});
          end
          "R": begin
            void'($fscanf(fd, "%h %h %h", a, b, c));
            apb_access(1'b0, a[`HCI_ADDR_W-1:0], '0, rdata, err);
            check_value({name, " prdata"}, b, rdata);
            check_value({name, " pslverr"}, c, {31'b0, err});
          end
          "P": begin
            void'($fscanf(fd, "%h %h", a, b));
            @(negedge clk);
            check_value({name, " wready"}, b, {31'b0, resp_wready});
            resp_wvalid = 1'b1;  // Dropped by the DUT when not ready
            resp_wdata  = a;
            @(negedge clk);
            resp_wvalid = 1'b0;
          end
          "C": begin
            void'($fscanf(fd, "%h", a));
            @(negedge clk);
            while (!cmd_rvalid) begin
              @(negedge clk);
            end
            check_value(name, a, cmd_rdata);
            cmd_rready = 1'b1;
            @(negedge clk);
            cmd_rready = 1'b0;
          end
          "E": begin
            void'($fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f));
            @(negedge clk);
            daa_event = {a[0], b[6:0], c[0], d[0], e[6:0], f[0]};
            @(negedge clk);
            daa_event = '0;
          end
          "A": begin
            void'($fscanf(fd, "%h %h", a, b));
            @(negedge clk);
            check_value(name, {24'b0, a[6:0], b[0]}, 32'(dyn_addr));
          end
          "T": begin
            void'($fscanf(fd, "%h %h", a, b));
            @(negedge clk);
            check_value(name, {30'b0, a[0], b[0]}, {30'b0, cmd_thld_trig, resp_thld_trig});
          end
          default: begin
            $display("Testbench failed");
            $fatal(1, "Unknown operation %s in the pattern file", op);
          end
        endcase
      end
    end
    $fclose(fd);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* hdl/hci_addr_ctrl.sv */
// One update per cycle: RSTDAA, SETDASA, SETNEWDA, SETAASA, then software
`timescale 1ns/1ps
`include "i3c_hci_params.svh"

module hci_addr_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  i3c_hci_pkg::daa_event_t     daa_event_i,
  input  logic [`HCI_DA_W-1:0]        static_addr_i,
  input  i3c_hci_pkg::addr_sw_wr_t    addr_sw_wr_i,
  output i3c_hci_pkg::dyn_addr_t      dyn_addr_o
);

  logic [`HCI_DA_W-1:0] addr_q;
  logic [`HCI_DA_W-1:0] addr_d;
  logic valid_q;
  logic valid_d;
  logic upd;

  always_comb begin
    upd     = 1'b1;
    addr_d  = addr_q;
    valid_d = valid_q;
    if (daa_event_i.rstdaa) begin
      addr_d  = '0;
      valid_d = 1'b0;
    end else if (daa_event_i.set_dasa) begin
      addr_d  = daa_event_i.dasa;
      valid_d = 1'b1;
    end else if (daa_event_i.set_newda) begin
      addr_d  = daa_event_i.newda;
      valid_d = 1'b1;
    end else if (daa_event_i.set_aasa) begin
      addr_d  = static_addr_i;  // Static address becomes dynamic
      valid_d = 1'b1;
    end else if (addr_sw_wr_i.we) begin
      addr_d  = addr_sw_wr_i.addr;
      valid_d = addr_sw_wr_i.valid;
    end else begin
      upd = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q  <= '0;
      valid_q <= 1'b0;
    end else if (upd) begin
      addr_q  <= addr_d;
      valid_q <= valid_d;
    end
  end

  assign dyn_addr_o.addr  = addr_q;
  assign dyn_addr_o.valid = valid_q;

endmodule

/* hdl/hci_csr_apb.sv */
// Zero wait state APB slave, no PSTRB; error accesses have no side effects
// Thresholds above the queue depth are stored as the depth
`timescale 1ns/1ps
`include "i3c_hci_params.svh"

module hci_csr_apb (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  i3c_hci_pkg::apb_req_t       apb_req_i,
  output i3c_hci_pkg::apb_rsp_t       apb_rsp_o,
  output logic                        cmd_push_o,
  input  logic                        cmd_full_i,
  output logic                        resp_pop_o,
  input  logic [`HCI_DATA_W-1:0]      resp_head_i,
  input  logic [`HCI_CNT_W-1:0]       resp_count_i,
  input  logic [`HCI_CNT_W-1:0]       cmd_count_i,
  output logic                        cmd_flush_o,
  output logic                        resp_flush_o,
  output logic [`HCI_DA_W-1:0]        static_addr_o,
  output i3c_hci_pkg::addr_sw_wr_t    addr_sw_wr_o,
  input  i3c_hci_pkg::dyn_addr_t      dyn_addr_i,
  output logic                        cmd_thld_trig_o,
  output logic                        resp_thld_trig_o
);

  localparam logic [`HCI_THLD_W-1:0] DepthThld = `HCI_THLD_W'(`HCI_QUEUE_DEPTH);

  logic access;
  logic err;
  logic wr_en;
  logic rd_en;
  logic sel_rst;
  logic sel_cmd;
  logic sel_resp;
  logic sel_thld;
  logic sel_stat;
  logic sel_addr;
  logic mapped;
  logic resp_empty;
  logic cmd_rst_q;
  logic resp_rst_q;
  logic [`HCI_THLD_W-1:0] cmd_thld_q;
  logic [`HCI_THLD_W-1:0] resp_thld_q;
  logic [`HCI_DA_W-1:0] static_addr_q;
  logic static_valid_q;
  logic [`HCI_CNT_W-1:0] cmd_free;
  logic [`HCI_DATA_W-1:0] rdata;

  function automatic logic [`HCI_THLD_W-1:0] clamp_thld(input logic [`HCI_THLD_W-1:0] val);
    return (val > DepthThld) ? DepthThld : val;
  endfunction

  // Address decode
  assign sel_rst  = (apb_req_i.paddr == `HCI_RESET_CONTROL_OFS);
  assign sel_cmd  = (apb_req_i.paddr == `HCI_COMMAND_PORT_OFS);
  assign sel_resp = (apb_req_i.paddr == `HCI_RESPONSE_PORT_OFS);
  assign sel_thld = (apb_req_i.paddr == `HCI_QUEUE_THLD_CTRL_OFS);
  assign sel_stat = (apb_req_i.paddr == `HCI_QUEUE_STATUS_OFS);
  assign sel_addr = (apb_req_i.paddr == `HCI_DEVICE_ADDR_OFS);
  assign mapped   = sel_rst | sel_cmd | sel_resp | sel_thld | sel_stat | sel_addr;

  assign access     = apb_req_i.psel & apb_req_i.penable;
  assign resp_empty = (resp_count_i == '0);

  assign err = access & (~mapped
                         | (apb_req_i.pwrite & sel_cmd & cmd_full_i)
                         | (~apb_req_i.pwrite & sel_resp & resp_empty));

  assign wr_en = access & apb_req_i.pwrite & ~err;
  assign rd_en = access & ~apb_req_i.pwrite & ~err;

  assign cmd_push_o = wr_en & sel_cmd;
  assign resp_pop_o = rd_en & sel_resp;  // Head leaves as it is read

  always_comb begin
    rdata = '0;
    if (sel_rst) begin
      rdata[1] = cmd_rst_q;
      rdata[2] = resp_rst_q;
    end
    if (sel_resp) begin
      rdata = resp_head_i;
    end
    if (sel_thld) begin
      rdata[15:0] = {resp_thld_q, cmd_thld_q};
    end
    if (sel_stat) begin
      rdata[`HCI_CNT_W-1:0] = cmd_count_i;
      rdata[8 +: `HCI_CNT_W] = resp_count_i;
    end
    if (sel_addr) begin
      rdata = {dyn_addr_i.valid, 8'b0, dyn_addr_i.addr, static_valid_q, 8'b0, static_addr_q};
    end
  end

  assign apb_rsp_o.prdata  = rd_en ? rdata : '0;
  assign apb_rsp_o.pslverr = err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q      <= 1'b0;
      resp_rst_q     <= 1'b0;
      cmd_thld_q     <= `HCI_THLD_RESET;
      resp_thld_q    <= `HCI_THLD_RESET;
      static_addr_q  <= '0;
      static_valid_q <= 1'b0;
    end else begin
      // Held for one cycle, the queue is empty after it
      cmd_rst_q  <= wr_en & sel_rst & apb_req_i.pwdata[1];
      resp_rst_q <= wr_en & sel_rst & apb_req_i.pwdata[2];
      if (wr_en && sel_thld) begin
        cmd_thld_q  <= clamp_thld(apb_req_i.pwdata[7:0]);
        resp_thld_q <= clamp_thld(apb_req_i.pwdata[15:8]);
      end
      if (wr_en && sel_addr) begin
        static_addr_q  <= apb_req_i.pwdata[`HCI_DA_W-1:0];
        static_valid_q <= apb_req_i.pwdata[15];
      end
    end
  end

  assign cmd_flush_o   = cmd_rst_q;
  assign resp_flush_o  = resp_rst_q;
  assign static_addr_o = static_addr_q;

  // Dynamic address lives in the address block
  assign addr_sw_wr_o.we    = wr_en & sel_addr;
  assign addr_sw_wr_o.addr  = apb_req_i.pwdata[16 +: `HCI_DA_W];
  assign addr_sw_wr_o.valid = apb_req_i.pwdata[31];

  // Free command slots against CMD_EMPTY_BUF_THLD
  assign cmd_free = `HCI_CNT_W'(`HCI_QUEUE_DEPTH) - cmd_count_i;
  assign cmd_thld_trig_o  = (`HCI_THLD_W'(cmd_free) >= cmd_thld_q);
  assign resp_thld_trig_o = (`HCI_THLD_W'(resp_count_i) >= resp_thld_q);

endmodule

/* hdl/hci_queue.sv */
// Register-array FIFO; CntW must hold the value Depth
// Flush wins over a push on the same edge
`timescale 1ns/1ps
`include "i3c_hci_params.svh"

module hci_queue #(
  parameter int unsigned Depth = `HCI_QUEUE_DEPTH,
  parameter int unsigned DataW = `HCI_DATA_W,
  parameter int unsigned CntW  = `HCI_CNT_W
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [DataW-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [DataW-1:0] rdata_o,
  output logic [CntW-1:0]  count_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  logic [DataW-1:0] mem_q [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] count_q;
  logic push;
  logic pop;

  // Wraps at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wready_o = (count_q != CntW'(Depth));
  assign rvalid_o = (count_q != '0);
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;
  assign rdata_o  = mem_q[rptr_q];
  assign count_o  = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

/* hdl/i3c_hci.sv */
// HCI core with command and response queues of HCI_QUEUE_DEPTH words
// APB has zero wait states; controller side uses valid/ready
`timescale 1ns/1ps
`include "i3c_hci_params.svh"

module i3c_hci (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  i3c_hci_pkg::apb_req_t    apb_req_i,
  output i3c_hci_pkg::apb_rsp_t    apb_rsp_o,
  output logic                     cmd_rvalid_o,
  input  logic                     cmd_rready_i,
  output logic [`HCI_DATA_W-1:0]   cmd_rdata_o,
  input  logic                     resp_wvalid_i,
  output logic                     resp_wready_o,
  input  logic [`HCI_DATA_W-1:0]   resp_wdata_i,
  input  i3c_hci_pkg::daa_event_t  daa_event_i,
  output i3c_hci_pkg::dyn_addr_t   dyn_addr_o,
  output logic                     cmd_thld_trig_o,
  output logic                     resp_thld_trig_o
);
  import i3c_hci_pkg::*;

  logic cmd_push;
  logic cmd_wready;
  logic cmd_full;
  logic cmd_flush;
  logic resp_pop;
  logic resp_flush;
  logic [`HCI_DATA_W-1:0] resp_head;
  logic [`HCI_CNT_W-1:0] cmd_count;
  logic [`HCI_CNT_W-1:0] resp_count;
  logic [`HCI_DA_W-1:0] static_addr;
  addr_sw_wr_t addr_sw_wr;

  assign cmd_full = ~cmd_wready;

  hci_csr_apb csr_i (
    .clk_i,
    .rst_ni,
    .apb_req_i,
    .apb_rsp_o,
    .cmd_push_o      (cmd_push),
    .cmd_full_i      (cmd_full),
    .resp_pop_o      (resp_pop),
    .resp_head_i     (resp_head),
    .resp_count_i    (resp_count),
    .cmd_count_i     (cmd_count),
    .cmd_flush_o     (cmd_flush),
    .resp_flush_o    (resp_flush),
    .static_addr_o   (static_addr),
    .addr_sw_wr_o    (addr_sw_wr),
    .dyn_addr_i      (dyn_addr_o),
    .cmd_thld_trig_o,
    .resp_thld_trig_o
  );

  // Software fills, controller drains
  hci_queue cmd_queue (
    .clk_i,
    .rst_ni,
    .flush_i  (cmd_flush),
    .wvalid_i (cmd_push),
    .wready_o (cmd_wready),
    .wdata_i  (apb_req_i.pwdata),
    .rvalid_o (cmd_rvalid_o),
    .rready_i (cmd_rready_i),
    .rdata_o  (cmd_rdata_o),
    .count_o  (cmd_count)
  );

  // Controller fills, software drains; empty is seen through the count
  hci_queue resp_queue (
    .clk_i,
    .rst_ni,
    .flush_i  (resp_flush),
    .wvalid_i (resp_wvalid_i),
    .wready_o (resp_wready_o),
    .wdata_i  (resp_wdata_i),
    .rvalid_o (),
    .rready_i (resp_pop),
    .rdata_o  (resp_head),
    .count_o  (resp_count)
  );

  hci_addr_ctrl addr_ctrl_i (
    .clk_i,
    .rst_ni,
    .daa_event_i,
    .static_addr_i (static_addr),
    .addr_sw_wr_i  (addr_sw_wr),
    .dyn_addr_o
  );

endmodule

/* hdl/i3c_hci_pkg.sv */
// Bus and event types of the HCI core; widths come from the params header
`include "i3c_hci_params.svh"

package i3c_hci_pkg;

  // APB request, PSTRB not carried
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`HCI_ADDR_W-1:0] paddr;
    logic [`HCI_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`HCI_DATA_W-1:0] prdata;
    logic                   pslverr;
  } apb_rsp_t;

  // Single-cycle strobes from the bus controller
  typedef struct packed {
    logic                 set_dasa;
    logic [`HCI_DA_W-1:0] dasa;
    logic                 rstdaa;
    logic                 set_newda;
    logic [`HCI_DA_W-1:0] newda;
    logic                 set_aasa;
  } daa_event_t;

  // Software write of DYNAMIC_ADDR and its valid bit
  typedef struct packed {
    logic                 we;
    logic [`HCI_DA_W-1:0] addr;
    logic                 valid;
  } addr_sw_wr_t;

  typedef struct packed {
    logic [`HCI_DA_W-1:0] addr;
    logic                 valid;
  } dyn_addr_t;

endpackage

/* i3c_hci.f */
+incdir+include
hdl/i3c_hci_pkg.sv
hdl/hci_queue.sv
hdl/hci_addr_ctrl.sv
hdl/hci_csr_apb.sv
hdl/i3c_hci.sv
dv/tb_i3c_hci.sv

/* include/i3c_hci_params.svh */
// Queue depth must fit in HCI_CNT_W bits and in a threshold field
// Register offsets are byte addresses of 32-bit registers
`ifndef I3C_HCI_PARAMS_SVH
`define I3C_HCI_PARAMS_SVH

`define HCI_DATA_W 32
`define HCI_ADDR_W 12
`define HCI_QUEUE_DEPTH 8
`define HCI_CNT_W 4
`define HCI_THLD_W 8
`define HCI_DA_W 7

// Register map
`define HCI_RESET_CONTROL_OFS 12'h010
`define HCI_COMMAND_PORT_OFS 12'h0C0
`define HCI_RESPONSE_PORT_OFS 12'h0C4
`define HCI_QUEUE_THLD_CTRL_OFS 12'h0D0
`define HCI_QUEUE_STATUS_OFS 12'h0D4
`define HCI_DEVICE_ADDR_OFS 12'h1A0

`define HCI_THLD_RESET 8'd1  // Both queue thresholds

`endif

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module tb_i3c_hci -f i3c_hci.f -o tb_i3c_hci &&
  ./obj_dir/tb_i3c_hci ||
  { echo "Simulation did not complete successfully"; exit 1; }
